/* tb.f */
design/exec_pkg.sv
design/exec_if.sv
design/inst_decoder.sv
design/bypass_exec.sv
design/lsu_mem.sv
design/exec_top.sv
verif/exec_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module exec_tb -f tb.f -o exec_sim
./obj_dir/exec_sim 2>&1 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "simulation run passed"
else
    echo "simulation run failed"
    exit 1
fi

/* verif/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    typedef enum logic [3:0] {K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_LW, K_SW, K_BEQ} kind_e;

    typedef struct packed {
        kind_e            kind;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [XLEN-1:0]  imm;
        logic [XLEN-1:0]  pc;
        logic             squash;
        logic             exp_wb;
        logic [XLEN-1:0]  exp_val;
        logic             exp_redir;
    } entry_t;

    logic             clk;
    logic             rst;
    logic             inst_valid;
    logic [XLEN-1:0]  inst;
    logic [XLEN-1:0]  inst_pc;
    logic             wb_valid;
    logic [REG_W-1:0] wb_rd;
    logic [XLEN-1:0]  wb_data;
    logic             redirect_valid;
    logic [XLEN-1:0]  redirect_pc;

    entry_t          tab [128];
    int              n_ent;
    int              errors;
    int              timeouts;
    logic [XLEN-1:0] model_regs [16];
    logic [XLEN-1:0] model_mem [64];

    exec_top i_exec_top (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // ==================================================
    // Stimulus table and reference model
    // ==================================================
    function automatic logic [XLEN-1:0] inst_word(input entry_t e);
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] m;
        rd  = {1'b0, e.rd};
        rs1 = {1'b0, e.rs1};
        rs2 = {1'b0, e.rs2};
        m   = e.imm;
        case (e.kind)
            K_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:   return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:    return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:   return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_ADDI:  return {m[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_LW:    return {m[11:0], rs1, 3'b010, rd, 7'b0000011};
            K_SW:    return {m[11:5], rs2, rs1, 3'b010, m[4:0], 7'b0100011};
            default: return {m[12], m[10:5], rs2, rs1, 3'b000, m[4:1], m[11], 7'b1100011};
        endcase
    endfunction

    task automatic add_op(input kind_e kind, input int rd, input int rs1, input int rs2,
                          input int imm);
        tab[n_ent]      = '0;
        tab[n_ent].kind = kind;
        tab[n_ent].rd   = REG_W'(rd);
        tab[n_ent].rs1  = REG_W'(rs1);
        tab[n_ent].rs2  = REG_W'(rs2);
        tab[n_ent].imm  = XLEN'(imm);
        tab[n_ent].pc   = 32'h100 + XLEN'(4 * n_ent);
        n_ent++;
    endtask

    task automatic build_table();
        int unsigned pick;
        void'($urandom(9));
        for (int r = 1; r < 16; r++) begin
            add_op(K_ADDI, r, 0, 0, r * 37 - 200);
        end
        add_op(K_ADD, 3, 1, 2, 0);
        add_op(K_SUB, 4, 2, 9, 0);
        add_op(K_AND, 5, 10, 15, 0);
        add_op(K_OR, 6, 7, 12, 0);
        add_op(K_XOR, 7, 14, 1, 0);
        add_op(K_ADDI, 8, 13, 0, -2048);
        add_op(K_ADDI, 9, 0, 0, 7);     // Chain at distance 1, 2 and 3.
        add_op(K_ADD, 10, 9, 9, 0);
        add_op(K_SUB, 11, 10, 9, 0);
        add_op(K_XOR, 12, 9, 11, 0);
        add_op(K_OR, 13, 10, 12, 0);
        add_op(K_ADDI, 2, 0, 0, 64);
        add_op(K_SW, 0, 2, 13, 8);
        add_op(K_LW, 14, 2, 0, 8);
        add_op(K_ADD, 15, 14, 14, 0);   // Uses the load right away.
        add_op(K_SW, 0, 2, 15, -4);
        add_op(K_LW, 1, 2, 0, -4);
        add_op(K_XOR, 3, 1, 14, 0);
        add_op(K_ADDI, 5, 0, 0, 3);
        add_op(K_ADDI, 6, 0, 0, 3);
        add_op(K_BEQ, 0, 5, 6, 16);     // Taken.
        add_op(K_ADDI, 7, 0, 0, 99);
        add_op(K_ADDI, 8, 0, 0, 98);
        add_op(K_ADD, 9, 5, 6, 0);
        add_op(K_BEQ, 0, 9, 5, -8);     // Not taken.
        add_op(K_ADDI, 10, 9, 0, 1);
        add_op(K_BEQ, 0, 0, 0, -64);
        add_op(K_SW, 0, 2, 10, 8);      // Squashed store must not land.
        add_op(K_ADDI, 11, 0, 0, 5);
        add_op(K_LW, 12, 2, 0, 8);
        add_op(K_ADDI, 0, 0, 0, 55);
        add_op(K_ADD, 4, 0, 0, 0);
        add_op(K_ADDI, 5, 0, 0, 1);
        add_op(K_OR, 6, 0, 5, 0);
        for (int r = 1; r < 16; r++) begin
            add_op(K_ADDI, r, 0, 0, int'($urandom % 4096) - 2048);
        end
        for (int k = 0; k < 32; k++) begin
            pick = $urandom % 6;
            add_op(kind_e'(4'(pick)), int'($urandom % 16), int'($urandom % 16),
                   int'($urandom % 16), int'($urandom % 4096) - 2048);
        end
    endtask

    task automatic run_model();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        int              shadow;
        shadow = 0;
        for (int r = 0; r < 16; r++) begin
            model_regs[r] = '0;
        end
        for (int i = 0; i < n_ent; i++) begin
            tab[i].squash = (shadow > 0);
            if (tab[i].squash) begin
                shadow--;
            end else begin
                a   = model_regs[tab[i].rs1];
                b   = model_regs[tab[i].rs2];
                res = a + tab[i].imm;  // ADDI result or byte address.
                case (tab[i].kind)
                    K_ADD:   res = a + b;
                    K_SUB:   res = a - b;
                    K_AND:   res = a & b;
                    K_OR:    res = a | b;
                    K_XOR:   res = a ^ b;
                    K_LW:    res = model_mem[res[7:2]];
                    K_SW:    model_mem[res[7:2]] = b;
                    K_BEQ:   tab[i].exp_redir = (a == b);
                    default: ;
                endcase
                tab[i].exp_wb  = (tab[i].kind != K_SW) && (tab[i].kind != K_BEQ);
                tab[i].exp_val = res;
                if (tab[i].exp_wb && tab[i].rd != '0) begin
                    model_regs[tab[i].rd] = res;
                end
                if (tab[i].exp_redir) begin
                    shadow = 2;  // Taken BEQ kills the next two strobes.
                end
            end
        end
    endtask

    // ==================================================
    // Drive and compare
    // ==================================================
    task automatic check_outputs(input int c);
        entry_t w;
        entry_t r;
        w = '0;
        r = '0;
        if (c >= 3 && c - 3 < n_ent) begin
            w = tab[c-3];
        end
        if (c >= 2 && c - 2 < n_ent) begin
            r = tab[c-2];
        end
        check_value($sformatf("entry %0d wb_valid", c - 3), 32'(wb_valid), 32'(w.exp_wb));
        if (w.exp_wb) begin
            check_value($sformatf("entry %0d wb_rd", c - 3), 32'(wb_rd), 32'(w.rd));
            check_value($sformatf("entry %0d wb_data", c - 3), wb_data, w.exp_val);
        end
        check_value($sformatf("entry %0d redirect_valid", c - 2), 32'(redirect_valid),
                    32'(r.exp_redir));
        if (r.exp_redir) begin
            check_value($sformatf("entry %0d redirect_pc", c - 2), redirect_pc, r.pc + r.imm);
        end
    endtask

    task automatic wait_idle(input int limit);
        int cycles;
        cycles = 0;
        while ((wb_valid || redirect_valid) && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (wb_valid || redirect_valid) begin
            timeouts++;
            $display("timeout at %0t: pipeline outputs did not return to idle", $time);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        errors     = 0;
        timeouts   = 0;
        n_ent      = 0;
        build_table();
        run_model();
        repeat (10) begin
            @(negedge clk);
            check_value("reset wb_valid", 32'(wb_valid), 32'd0);
            check_value("reset redirect_valid", 32'(redirect_valid), 32'd0);
        end
        rst = 1'b0;
        for (int c = 0; c < n_ent + 3; c++) begin
            check_outputs(c);
            inst_valid = (c < n_ent);
            inst       = (c < n_ent) ? inst_word(tab[c]) : '0;
            inst_pc    = (c < n_ent) ? tab[c].pc : '0;
            @(negedge clk);
        end
        wait_idle(8);
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* design/exec_top.sv */
`timescale 1ns/1ps

module exec_top import exec_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid,
    input  logic [XLEN-1:0]  inst,
    input  logic [XLEN-1:0]  inst_pc,
    output logic             wb_valid,
    output logic [REG_W-1:0] wb_rd,
    output logic [XLEN-1:0]  wb_data,
    output logic             redirect_valid,
    output logic [XLEN-1:0]  redirect_pc
);

    exec_if dec_bus ();

    logic            flush;
    logic            mreq_valid;
    mem_req_t        mreq;
    logic [XLEN-1:0] load_data;

    inst_decoder i_inst_decoder (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .flush      (flush),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .dec        (dec_bus.producer)
    );

    bypass_exec i_bypass_exec (
        .clk         (clk),
        .rst         (rst),
        .dec         (dec_bus.consumer),
        .load_data   (load_data),
        .mreq_valid  (mreq_valid),
        .mreq        (mreq),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

    lsu_mem i_lsu_mem (
        .clk        (clk),
        .rst        (rst),
        .mreq_valid (mreq_valid),
        .mreq       (mreq),
        .load_data  (load_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    assign redirect_valid = flush;  // Taken BEQ, two cycles after strobe.

endmodule

/* design/lsu_mem.sv */
`timescale 1ns/1ps

module lsu_mem import exec_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             mreq_valid,
    input  mem_req_t         mreq,
    output logic [XLEN-1:0]  load_data,
    output logic             wb_valid,
    output logic [REG_W-1:0] wb_rd,
    output logic [XLEN-1:0]  wb_data
);

    logic [XLEN-1:0]    mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic               is_load;
    logic               is_store;

    assign word_idx = mreq.result[DMEM_AW+1:2];  // Word addressed.
    assign is_load  = (mreq.kind == OP_LOAD);
    assign is_store = (mreq.kind == OP_STORE);

    // Also feeds the bypass for the pending load slot.
    assign load_data = mem[word_idx];

    always_ff @(posedge clk) begin
        if (mreq_valid && is_store) begin
            mem[word_idx] <= mreq.store_data;
        end
    end

    // ==================================================
    // Writeback
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mreq_valid && mreq.we;
        end
    end

    always_ff @(posedge clk) begin
        if (mreq_valid && mreq.we) begin
            wb_rd   <= mreq.rd;
            wb_data <= is_load ? load_data : mreq.result;
        end
    end

endmodule

/* design/bypass_exec.sv */
`timescale 1ns/1ps

module bypass_exec import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    exec_if.consumer        dec,
    input  logic [XLEN-1:0] load_data,
    output logic            mreq_valid,
    output mem_req_t        mreq,
    output logic            flush,
    output logic [XLEN-1:0] redirect_pc
);

    // Slot 0 is the newest result.
    logic [REG_W-1:0]        slot_rd   [BYPASS_DEPTH];
    logic [XLEN-1:0]         slot_data [BYPASS_DEPTH];
    logic [BYPASS_DEPTH-1:0] slot_valid;
    logic [BYPASS_DEPTH-1:0] slot_load;

    logic            go;
    logic            push;
    logic            taken;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b_reg;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;

    // ==================================================
    // Operand forwarding
    // ==================================================
    function automatic logic [XLEN-1:0] fwd_operand(input logic [REG_W-1:0] rs,
                                                    input logic [XLEN-1:0]  rf_val);
        logic [XLEN-1:0] val;
        val = rf_val;
        for (int k = BYPASS_DEPTH - 1; k >= 0; k--) begin
            if (slot_valid[k] && slot_rd[k] == rs && rs != '0) begin
                val = slot_load[k] ? load_data : slot_data[k];  // Newest wins.
            end
        end
        return val;
    endfunction

    assign go   = dec.valid && !flush;  // Branch successor is dropped.
    assign push = go && dec.op.we;

    always_comb begin
        op_a     = fwd_operand(dec.op.rs1, dec.op.rs1_val);
        op_b_reg = fwd_operand(dec.op.rs2, dec.op.rs2_val);
    end

    assign op_b = dec.op.imm_sel ? dec.op.imm : op_b_reg;

    // ==================================================
    // ALU and branch compare
    // ==================================================
    always_comb begin
        case (dec.op.kind)
            OP_SUB:  alu_out = op_a - op_b;
            OP_AND:  alu_out = op_a & op_b;
            OP_OR:   alu_out = op_a | op_b;
            OP_XOR:  alu_out = op_a ^ op_b;
            default: alu_out = op_a + op_b;  // ADD, ADDI and addresses.
        endcase
    end

    assign taken = go && (dec.op.kind == OP_BEQ) && (op_a == op_b_reg);

    // ==================================================
    // Bypass buffer
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_valid <= '0;
            slot_load  <= '0;
        end else begin
            slot_load <= '0;  // Pending loads fill every cycle.
            if (push) begin
                slot_valid   <= {slot_valid[BYPASS_DEPTH-2:0], 1'b1};
                slot_load[0] <= (dec.op.kind == OP_LOAD);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < BYPASS_DEPTH; k++) begin
            if (slot_load[k]) begin
                slot_data[k] <= load_data;
            end
        end
        if (push) begin
            for (int k = BYPASS_DEPTH - 1; k > 0; k--) begin
                slot_rd[k]   <= slot_rd[k-1];
                slot_data[k] <= slot_load[k-1] ? load_data : slot_data[k-1];
            end
            slot_rd[0]   <= dec.op.rd;
            slot_data[0] <= alu_out;
        end
    end

    // ==================================================
    // Request to LSU and redirect
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mreq_valid <= 1'b0;
            flush      <= 1'b0;
        end else begin
            mreq_valid <= go && (dec.op.kind != OP_BEQ);
            flush      <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            mreq <= '{kind: dec.op.kind, rd: dec.op.rd, we: dec.op.we,
                      result: alu_out, store_data: op_b_reg};
        end
        if (taken) begin
            redirect_pc <= dec.op.pc + dec.op.imm;
        end
    end

endmodule

/* design/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import exec_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid,
    input  inst_u            inst,
    input  logic [XLEN-1:0]  inst_pc,
    input  logic             flush,
    input  logic             wb_valid,
    input  logic [REG_W-1:0] wb_rd,
    input  logic [XLEN-1:0]  wb_data,
    exec_if.producer         dec
);

    logic [XLEN-1:0]  regs [2**REG_W];
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [REG_W-1:0] rd;
    logic [XLEN-1:0]  rs1_val;
    logic [XLEN-1:0]  rs2_val;
    op_kind_e         op_kind;
    logic [XLEN-1:0]  op_imm;
    logic             op_imm_sel;
    logic             op_we;
    logic             legal;

    assign rs1 = inst.r.rs1[REG_W-1:0];
    assign rs2 = inst.r.rs2[REG_W-1:0];
    assign rd  = inst.r.rd[REG_W-1:0];

    // ==================================================
    // Instruction decode
    // ==================================================
    always_comb begin
        op_kind    = OP_ADD;
        op_imm     = '0;
        op_imm_sel = 1'b0;
        op_we      = 1'b0;
        legal      = 1'b0;
        case (inst.r.opcode)
            OPC_OP: begin
                op_we = 1'b1;
                legal = 1'b1;
                case ({inst.r.funct7, inst.r.funct3})
                    {F7_BASE, F3_ADD}: op_kind = OP_ADD;
                    {F7_SUB, F3_ADD}:  op_kind = OP_SUB;
                    {F7_BASE, F3_XOR}: op_kind = OP_XOR;
                    {F7_BASE, F3_OR}:  op_kind = OP_OR;
                    {F7_BASE, F3_AND}: op_kind = OP_AND;
                    default:           legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin  // ADDI only.
                op_kind    = OP_ADD;
                op_imm     = {{20{inst.i.imm12[11]}}, inst.i.imm12};
                op_imm_sel = 1'b1;
                op_we      = 1'b1;
                legal      = (inst.i.funct3 == F3_ADD);
            end
            OPC_LOAD: begin
                op_kind    = OP_LOAD;
                op_imm     = {{20{inst.i.imm12[11]}}, inst.i.imm12};
                op_imm_sel = 1'b1;
                op_we      = 1'b1;
                legal      = (inst.i.funct3 == F3_WORD);
            end
            OPC_STORE: begin
                op_kind    = OP_STORE;
                op_imm     = {{20{inst.r.funct7[6]}}, inst.r.funct7, inst.r.rd};
                op_imm_sel = 1'b1;
                legal      = (inst.r.funct3 == F3_WORD);
            end
            OPC_BRANCH: begin
                op_kind = OP_BEQ;
                op_imm  = {{19{inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rd[0],
                           inst.r.funct7[5:0], inst.r.rd[4:1], 1'b0};
                legal   = (inst.r.funct3 == F3_BEQ);
            end
            default: legal = 1'b0;
        endcase
    end

    // ==================================================
    // Register file
    // ==================================================
    always_comb begin
        rs1_val = regs[rs1];
        rs2_val = regs[rs2];
        if (wb_valid && wb_rd == rs1) rs1_val = wb_data;  // Write-through.
        if (wb_valid && wb_rd == rs2) rs2_val = wb_data;
        if (rs1 == '0) rs1_val = '0;
        if (rs2 == '0) rs2_val = '0;
    end

    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Flush drops the second slot of the branch shadow.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= inst_valid && legal && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec.op <= '{kind: op_kind, rd: rd, rs1: rs1, rs2: rs2,
                        rs1_val: rs1_val, rs2_val: rs2_val, imm: op_imm,
                        imm_sel: op_imm_sel, we: op_we, pc: inst_pc};
        end
    end

endmodule

/* design/exec_if.sv */
`timescale 1ns/1ps

interface exec_if import exec_pkg::*; ();

    logic    valid;  // One cycle per decoded op.
    dec_op_t op;

    modport producer (
        output valid,
        output op
    );

    modport consumer (
        input valid,
        input op
    );

endinterface

/* design/exec_pkg.sv */
package exec_pkg;

    // ==================================================
    // Widths and sizes
    // ==================================================
    localparam int XLEN         = 32;
    localparam int REG_W        = 4;
    localparam int BYPASS_DEPTH = 2;
    localparam int DMEM_WORDS   = 64;
    localparam int DMEM_AW      = $clog2(DMEM_WORDS);

    // ==================================================
    // RV32 encodings
    // ==================================================
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;  // LW and SW.
    localparam logic [2:0] F3_BEQ  = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LOAD,
        OP_STORE,
        OP_BEQ
    } op_kind_e;

    // R view. S and B formats carry immediate bits in funct7 and rd.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef struct packed {
        op_kind_e         kind;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [XLEN-1:0]  rs1_val;
        logic [XLEN-1:0]  rs2_val;
        logic [XLEN-1:0]  imm;
        logic             imm_sel;
        logic             we;
        logic [XLEN-1:0]  pc;
    } dec_op_t;

    typedef struct packed {
        op_kind_e         kind;
        logic [REG_W-1:0] rd;
        logic             we;
        logic [XLEN-1:0]  result;      // ALU result or byte address.
        logic [XLEN-1:0]  store_data;
    } mem_req_t;

endpackage
